// ==== design/log_ic_pkg.sv ====
package log_ic_pkg;

  // low address bits that select a byte inside one word
  localparam int unsigned BYTE_OFF_W = 2;

  // default data width, one 32-bit word
  localparam int unsigned DEFAULT_DW = 32;

  // default core byte address width
  localparam int unsigned DEFAULT_AW = 16;

  // access kind as carried on the wen lines
  // wen is active low on the bus: 0 writes, 1 reads
  typedef enum logic {
    OP_WRITE = 1'b0,
    OP_READ  = 1'b1
  } op_e;

endpackage

// ==== design/bank_rr_arbiter.sv ====
`timescale 1ns/1ps

module bank_rr_arbiter #(
  parameter  int unsigned N_CORE = 4,
  localparam int unsigned IDX_W  = (N_CORE > 1) ? $clog2(N_CORE) : 1
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic [N_CORE-1:0] req_i,
  output logic [N_CORE-1:0] gnt_o,
  output logic [IDX_W-1:0]  idx_o
);

  logic [IDX_W-1:0] ptr_q;  // first core looked at this cycle
  logic [IDX_W-1:0] cand;
  logic             found;

  // scan upward from the pointer, wrapping at N_CORE
  always_comb begin
    gnt_o = '0;
    idx_o = '0;
    found = 1'b0;
    cand  = '0;
    for (int unsigned k = 0; k < N_CORE; k++) begin
      cand = IDX_W'((32'(ptr_q) + k) % N_CORE);
      if (!found && req_i[cand]) begin
        found       = 1'b1;
        idx_o       = cand;
        gnt_o[cand] = 1'b1;
      end
    end
  end

  // after a grant the winner goes to the back of the queue
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (found) begin
      if (32'(idx_o) == N_CORE - 1) begin
        ptr_q <= '0;  // wrap
      end else begin
        ptr_q <= idx_o + 1'b1;
      end
    end
  end

endmodule

// ==== design/log_interconnect.sv ====
`timescale 1ns/1ps

module log_interconnect
  import log_ic_pkg::*;
#(
  parameter  int unsigned N_CORE     = 4,
  parameter  int unsigned N_BANK     = 4,
  parameter  int unsigned AW         = DEFAULT_AW,
  parameter  int unsigned DW         = DEFAULT_DW,
  parameter  int unsigned BANK_WORDS = 64,
  localparam int unsigned CORE_W     = (N_CORE > 1) ? $clog2(N_CORE) : 1,
  localparam int unsigned BANK_W     = (N_BANK > 1) ? $clog2(N_BANK) : 1,
  localparam int unsigned WA_W       = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  // core side
  input  logic [N_CORE-1:0]                core_req_i,
  input  logic [N_CORE-1:0][AW-1:0]        core_add_i,
  input  logic [N_CORE-1:0]                core_wen_i,
  input  logic [N_CORE-1:0][DW-1:0]        core_wdata_i,
  input  logic [N_CORE-1:0][DW/8-1:0]      core_be_i,
  output logic [N_CORE-1:0]                core_gnt_o,
  output logic [N_CORE-1:0]                core_r_valid_o,
  output logic [N_CORE-1:0][DW-1:0]        core_r_rdata_o,
  // bank side
  output logic [N_BANK-1:0]                mem_req_o,
  output logic [N_BANK-1:0][WA_W-1:0]      mem_add_o,
  output op_e  [N_BANK-1:0]                mem_wen_o,
  output logic [N_BANK-1:0][DW-1:0]        mem_wdata_o,
  output logic [N_BANK-1:0][DW/8-1:0]      mem_be_o,
  input  logic [N_BANK-1:0][DW-1:0]        mem_rdata_i
);

  logic [N_CORE-1:0][AW-1:0]     core_word;  // byte address without the offset
  logic [N_CORE-1:0][BANK_W-1:0] core_bank;
  logic [N_CORE-1:0][WA_W-1:0]   core_wadd;

  logic [N_BANK-1:0][N_CORE-1:0] bank_req;
  logic [N_BANK-1:0][N_CORE-1:0] bank_gnt;
  logic [N_BANK-1:0][CORE_W-1:0] bank_win;

  // word interleaving: low word bits pick the bank
  for (genvar c = 0; c < N_CORE; c++) begin : g_decode
    assign core_word[c] = core_add_i[c] >> BYTE_OFF_W;
    assign core_bank[c] = BANK_W'(core_word[c] % N_BANK);
    assign core_wadd[c] = WA_W'(core_word[c] / N_BANK);  // truncated to bank depth
  end

  for (genvar b = 0; b < N_BANK; b++) begin : g_bank
    for (genvar c = 0; c < N_CORE; c++) begin : g_req
      assign bank_req[b][c] = core_req_i[c] && (32'(core_bank[c]) == b);
    end

    bank_rr_arbiter #(
      .N_CORE ( N_CORE )
    ) i_arb (
      .clk_i   ( clk_i       ),
      .rst_n_i ( rst_n_i     ),
      .req_i   ( bank_req[b] ),
      .gnt_o   ( bank_gnt[b] ),
      .idx_o   ( bank_win[b] )
    );

    // winner's fields onto the bank port
    assign mem_req_o[b]   = |bank_req[b];
    assign mem_add_o[b]   = core_wadd[bank_win[b]];
    assign mem_wen_o[b]   = op_e'(core_wen_i[bank_win[b]]);
    assign mem_wdata_o[b] = core_wdata_i[bank_win[b]];
    assign mem_be_o[b]    = core_be_i[bank_win[b]];
  end

  // a core targets one bank at most, so OR-ing is safe
  always_comb begin
    core_gnt_o = '0;
    for (int unsigned b = 0; b < N_BANK; b++) begin
      core_gnt_o = core_gnt_o | bank_gnt[b];
    end
  end

  // response path, one cycle behind the grant
  for (genvar c = 0; c < N_CORE; c++) begin : g_rsp
    logic              rsp_vld_q;
    logic [BANK_W-1:0] rsp_bank_q;
    op_e               rsp_op_q;

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        rsp_vld_q  <= 1'b0;
        rsp_bank_q <= '0;
        rsp_op_q   <= OP_WRITE;
      end else begin
        rsp_vld_q <= core_gnt_o[c];
        if (core_gnt_o[c]) begin
          rsp_bank_q <= core_bank[c];
          rsp_op_q   <= op_e'(core_wen_i[c]);
        end
      end
    end

    assign core_r_valid_o[c] = rsp_vld_q;
    // writes answer with zero data
    assign core_r_rdata_o[c] = (rsp_vld_q && rsp_op_q == OP_READ) ?
                               mem_rdata_i[rsp_bank_q] : '0;
  end

endmodule

// ==== design/tcdm_bank.sv ====
`timescale 1ns/1ps

module tcdm_bank
  import log_ic_pkg::*;
#(
  parameter  int unsigned DW         = DEFAULT_DW,
  parameter  int unsigned BANK_WORDS = 64,
  localparam int unsigned WA_W       = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1
) (
  input  logic            clk_i,
  input  logic            req_i,
  input  logic [WA_W-1:0] add_i,    // word address
  input  op_e             wen_i,
  input  logic [DW-1:0]   wdata_i,
  input  logic [DW/8-1:0] be_i,
  output logic [DW-1:0]   rdata_o
);

  logic [DW-1:0] mem_q [BANK_WORDS];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (wen_i == OP_WRITE) begin
        // only enabled bytes change
        for (int unsigned i = 0; i < DW/8; i++) begin
          if (be_i[i]) begin
            mem_q[add_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[add_i];  // valid next cycle
      end
    end
  end

endmodule

// ==== design/tcdm_subsystem.sv ====
`timescale 1ns/1ps

module tcdm_subsystem
  import log_ic_pkg::*;
#(
  parameter  int unsigned N_CORE     = 4,
  parameter  int unsigned N_BANK     = 4,
  parameter  int unsigned AW         = DEFAULT_AW,
  parameter  int unsigned DW         = DEFAULT_DW,
  parameter  int unsigned BANK_WORDS = 64,
  localparam int unsigned WA_W       = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic [N_CORE-1:0]           core_req_i,
  input  logic [N_CORE-1:0][AW-1:0]   core_add_i,
  input  logic [N_CORE-1:0]           core_wen_i,
  input  logic [N_CORE-1:0][DW-1:0]   core_wdata_i,
  input  logic [N_CORE-1:0][DW/8-1:0] core_be_i,
  output logic [N_CORE-1:0]           core_gnt_o,
  output logic [N_CORE-1:0]           core_r_valid_o,
  output logic [N_CORE-1:0][DW-1:0]   core_r_rdata_o
);

  // interconnect to bank wiring
  logic [N_BANK-1:0]           mem_req;
  logic [N_BANK-1:0][WA_W-1:0] mem_add;
  op_e  [N_BANK-1:0]           mem_wen;
  logic [N_BANK-1:0][DW-1:0]   mem_wdata;
  logic [N_BANK-1:0][DW/8-1:0] mem_be;
  logic [N_BANK-1:0][DW-1:0]   mem_rdata;

  log_interconnect #(
    .N_CORE     ( N_CORE     ),
    .N_BANK     ( N_BANK     ),
    .AW         ( AW         ),
    .DW         ( DW         ),
    .BANK_WORDS ( BANK_WORDS )
  ) i_log_interconnect (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .core_req_i     ( core_req_i     ),
    .core_add_i     ( core_add_i     ),
    .core_wen_i     ( core_wen_i     ),
    .core_wdata_i   ( core_wdata_i   ),
    .core_be_i      ( core_be_i      ),
    .core_gnt_o     ( core_gnt_o     ),
    .core_r_valid_o ( core_r_valid_o ),
    .core_r_rdata_o ( core_r_rdata_o ),
    .mem_req_o      ( mem_req        ),
    .mem_add_o      ( mem_add        ),
    .mem_wen_o      ( mem_wen        ),
    .mem_wdata_o    ( mem_wdata      ),
    .mem_be_o       ( mem_be         ),
    .mem_rdata_i    ( mem_rdata      )
  );

  for (genvar b = 0; b < N_BANK; b++) begin : g_bank
    tcdm_bank #(
      .DW         ( DW         ),
      .BANK_WORDS ( BANK_WORDS )
    ) i_bank (
      .clk_i   ( clk_i        ),
      .req_i   ( mem_req[b]   ),
      .add_i   ( mem_add[b]   ),
      .wen_i   ( mem_wen[b]   ),
      .wdata_i ( mem_wdata[b] ),
      .be_i    ( mem_be[b]    ),
      .rdata_o ( mem_rdata[b] )
    );
  end

endmodule

// ==== dv/tcdm_subsystem_asserts.sv ====
`timescale 1ns/1ps

module tcdm_subsystem_asserts
  import log_ic_pkg::*;
#(
  parameter int unsigned N_CORE     = 4,
  parameter int unsigned N_BANK     = 4,
  parameter int unsigned AW         = DEFAULT_AW,
  parameter int unsigned DW         = DEFAULT_DW,
  parameter int unsigned BANK_WORDS = 64
) (
  input logic                        clk_i,
  input logic                        rst_n_i,
  input logic [N_CORE-1:0]           core_req_i,
  input logic [N_CORE-1:0][AW-1:0]   core_add_i,
  input logic [N_CORE-1:0]           core_wen_i,
  input logic [N_CORE-1:0][DW-1:0]   core_wdata_i,
  input logic [N_CORE-1:0][DW/8-1:0] core_be_i,
  input logic [N_CORE-1:0]           core_gnt_o,
  input logic [N_CORE-1:0]           core_r_valid_o,
  input logic [N_CORE-1:0][DW-1:0]   core_r_rdata_o
);

  localparam int unsigned WORDS = N_BANK * BANK_WORDS;  // whole cluster

  int unsigned               err_cnt = 0;
  logic                      in_rst_q = 1'b0;
  logic [N_CORE-1:0]         acc_q;  // granted on the last edge
  logic [N_CORE-1:0][DW-1:0] exp_q;
  int unsigned               wait_q [N_CORE];  // cycles spent waiting for a grant
  logic [DW-1:0]             shadow [WORDS];

  function automatic int unsigned word_idx(input logic [AW-1:0] add);
    return (32'(add) >> BYTE_OFF_W) % WORDS;
  endfunction

  function automatic int unsigned bank_of(input logic [AW-1:0] add);
    return (32'(add) >> BYTE_OFF_W) % N_BANK;
  endfunction

  // two granted cores on one bank in the same cycle
  function automatic logic bank_clash(input logic [N_CORE-1:0] taken,
                                      input logic [N_CORE-1:0][AW-1:0] add);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < N_CORE; i++) begin
      for (int j = i + 1; j < N_CORE; j++) begin
        if (taken[i] && taken[j] && bank_of(add[i]) == bank_of(add[j])) begin
          hit = 1'b1;
        end
      end
    end
    return hit;
  endfunction

  always @(posedge clk_i) begin : track
    int unsigned w;
    in_rst_q <= !rst_n_i;
    if (!rst_n_i) begin
      acc_q <= '0;
      for (int c = 0; c < N_CORE; c++) begin
        wait_q[c] <= 0;
      end
    end else begin
      acc_q <= core_req_i & core_gnt_o;
      for (int c = 0; c < N_CORE; c++) begin
        w = word_idx(core_add_i[c]);
        wait_q[c] <= (core_req_i[c] && !core_gnt_o[c]) ? wait_q[c] + 1 : 0;
        if (core_req_i[c] && core_gnt_o[c]) begin
          if (op_e'(core_wen_i[c]) == OP_READ) begin
            exp_q[c] <= shadow[w];  // value before this edge
          end else begin
            exp_q[c] <= '0;
            for (int b = 0; b < DW/8; b++) begin
              if (core_be_i[c][b]) begin
                shadow[w][b*8 +: 8] <= core_wdata_i[c][b*8 +: 8];
              end
            end
          end
        end
      end
    end
  end

  for (genvar c = 0; c < N_CORE; c++) begin : g_core
    a_gnt_needs_req: assert property (@(posedge clk_i) !core_req_i[c] |-> !core_gnt_o[c])
      else begin
        err_cnt++;
        $error("CHECK FAILED t=%0t core %0d granted without a request", $time, c);
      end

    a_rst_quiet: assert property (@(posedge clk_i)
        (!rst_n_i && in_rst_q) |-> !core_r_valid_o[c])
      else begin
        err_cnt++;
        $error("CHECK FAILED t=%0t core %0d r_valid high in reset", $time, c);
      end

    a_rsp_follows: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (core_req_i[c] && core_gnt_o[c]) |=> core_r_valid_o[c])
      else begin
        err_cnt++;
        $error("CHECK FAILED t=%0t core %0d no response after grant", $time, c);
      end

    a_rsp_only: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        core_r_valid_o[c] |-> acc_q[c])
      else begin
        err_cnt++;
        $error("CHECK FAILED t=%0t core %0d response without grant", $time, c);
      end

    a_rsp_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        core_r_valid_o[c] |-> core_r_rdata_o[c] == exp_q[c])
      else begin
        err_cnt++;
        $error("CHECK FAILED t=%0t core %0d rdata %h expected %h", $time, c,
               core_r_rdata_o[c], exp_q[c]);
      end

    // round robin bounds the wait
    a_no_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (core_req_i[c] && !core_gnt_o[c]) |-> wait_q[c] < N_CORE - 1)
      else begin
        err_cnt++;
        $error("CHECK FAILED t=%0t core %0d stalled for %0d cycles", $time, c, N_CORE);
      end
  end

  a_one_per_bank: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !bank_clash(core_req_i & core_gnt_o, core_add_i))
    else begin
      err_cnt++;
      $error("CHECK FAILED t=%0t two cores granted on one bank", $time);
    end

endmodule

// ==== dv/tcdm_subsystem_tb.sv ====
`timescale 1ns/1ps

module tcdm_subsystem_tb import log_ic_pkg::*; ();

  localparam int unsigned N_CORE        = 4;
  localparam int unsigned N_BANK        = 4;
  localparam int unsigned AW            = 16;
  localparam int unsigned DW            = 32;
  localparam int unsigned BANK_WORDS    = 64;
  localparam int unsigned N_MIXED       = 60;  // mixed accesses per core
  localparam int unsigned GNT_TIMEOUT   = 50;
  localparam int unsigned DRAIN_TIMEOUT = 10;

  logic                        clk;
  logic                        rst_n;
  logic [N_CORE-1:0]           core_req;
  logic [N_CORE-1:0][AW-1:0]   core_add;
  logic [N_CORE-1:0]           core_wen;
  logic [N_CORE-1:0][DW-1:0]   core_wdata;
  logic [N_CORE-1:0][DW/8-1:0] core_be;
  logic [N_CORE-1:0]           core_gnt;
  logic [N_CORE-1:0]           core_r_valid;
  logic [N_CORE-1:0][DW-1:0]   core_r_rdata;

  logic [N_CORE-1:0] granted_q;  // req and gnt seen on the last rising edge
  logic [31:0]       rng_q [N_CORE];

  tcdm_subsystem #(
    .N_CORE     ( N_CORE     ),
    .N_BANK     ( N_BANK     ),
    .AW         ( AW         ),
    .DW         ( DW         ),
    .BANK_WORDS ( BANK_WORDS )
  ) dut (
    .clk_i          ( clk          ),
    .rst_n_i        ( rst_n        ),
    .core_req_i     ( core_req     ),
    .core_add_i     ( core_add     ),
    .core_wen_i     ( core_wen     ),
    .core_wdata_i   ( core_wdata   ),
    .core_be_i      ( core_be      ),
    .core_gnt_o     ( core_gnt     ),
    .core_r_valid_o ( core_r_valid ),
    .core_r_rdata_o ( core_r_rdata )
  );

  bind tcdm_subsystem tcdm_subsystem_asserts #(
    .N_CORE     ( N_CORE     ),
    .N_BANK     ( N_BANK     ),
    .AW         ( AW         ),
    .DW         ( DW         ),
    .BANK_WORDS ( BANK_WORDS )
  ) i_asserts (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    granted_q <= core_req & core_gnt;
  end

  // stop at the first failed assertion
  always @(negedge clk) begin
    if (dut.i_asserts.err_cnt != 0) begin
      $display("TEST FAILED");
      $fatal(1, "an assertion in the bound checker failed");
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand(input int c);
    rng_q[c] = xorshift32(rng_q[c]);
    return rng_q[c];
  endfunction

  // called on a falling edge, returns on the falling edge after the grant
  task automatic issue(input int c, input logic [AW-1:0] add, input op_e op,
                       input logic [DW-1:0] wdata, input logic [DW/8-1:0] be);
    int unsigned n;
    n = 0;
    core_req[c]   = 1'b1;
    core_add[c]   = add;
    core_wen[c]   = op;
    core_wdata[c] = wdata;
    core_be[c]    = be;
    do begin
      @(negedge clk);
      n++;
      if (!granted_q[c] && n >= GNT_TIMEOUT) begin
        $display("TEST FAILED");
        $fatal(1, "core %0d waited %0d cycles for a grant", c, n);
      end
    end while (!granted_q[c]);
    core_req[c] = 1'b0;
  endtask

  // core c fills words 8c..8c+7, all cores hit the same bank each step
  task automatic write_phase(input int c);
    logic [31:0] r;
    for (int i = 0; i < 8; i++) begin
      r = next_rand(c);
      issue(c, AW'({8 * c + i, r[1:0]}), OP_WRITE, next_rand(c), '1);
    end
  endtask

  task automatic mixed_phase(input int c);
    logic [31:0] r;
    for (int i = 0; i < N_MIXED; i++) begin
      r = next_rand(c);
      if (r[11:10] == 2'b00) begin
        @(negedge clk);  // idle cycle
      end
      issue(c, AW'({r[4:0], r[13:12]}), r[5] ? OP_READ : OP_WRITE, next_rand(c), r[9:6]);
    end
  endtask

  initial begin
    int unsigned n;
    rst_n      = 1'b0;
    core_req   = '0;
    core_add   = '0;
    core_wen   = '0;
    core_wdata = '0;
    core_be    = '0;
    for (int c = 0; c < N_CORE; c++) begin
      rng_q[c] = 32'hc6bd + c;
    end
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    for (int c = 0; c < N_CORE; c++) begin
      fork
        automatic int k = c;
        write_phase(k);
      join_none
    end
    wait fork;

    for (int c = 0; c < N_CORE; c++) begin
      fork
        automatic int k = c;
        mixed_phase(k);
      join_none
    end
    wait fork;

    n = 0;
    while (core_r_valid != '0) begin
      if (n >= DRAIN_TIMEOUT) begin
        $display("TEST FAILED");
        $fatal(1, "responses still in flight after %0d cycles", n);
      end
      @(negedge clk);
      n++;
    end

    if (dut.i_asserts.err_cnt != 0) begin
      $display("TEST FAILED");
      $fatal(1, "the bound checker counted %0d errors", dut.i_asserts.err_cnt);
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

// ==== tcdm_subsystem.f ====
design/log_ic_pkg.sv
design/bank_rr_arbiter.sv
design/log_interconnect.sv
design/tcdm_bank.sv
design/tcdm_subsystem.sv
dv/tcdm_subsystem_asserts.sv
dv/tcdm_subsystem_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing -Wno-fatal -j 0
TOP       ?= tcdm_subsystem_tb
FLIST     ?= tcdm_subsystem.f
OBJ_DIR   ?= obj_dir
RUN_FLAGS ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS)

clean:
	rm -rf $(OBJ_DIR)
